//--- verilog/mips_pkg.sv
package mips_pkg;

  // Instruction formats, all overlaid on one 32-bit word
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] index;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_t;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'd0,
    OP_J       = 6'd2,
    OP_JAL     = 6'd3,
    OP_BEQ     = 6'd4,
    OP_BNE     = 6'd5,
    OP_ADDIU   = 6'd9,
    OP_SLTI    = 6'd10,
    OP_ANDI    = 6'd12,
    OP_ORI     = 6'd13,
    OP_XORI    = 6'd14,
    OP_LUI     = 6'd15,
    OP_LW      = 6'd35,
    OP_SW      = 6'd43
  } opcode_e;

  typedef enum logic [5:0] {
    F_SLL  = 6'd0,
    F_SRL  = 6'd2,
    F_SRA  = 6'd3,
    F_SLLV = 6'd4,
    F_SRLV = 6'd6,
    F_SRAV = 6'd7,
    F_JR   = 6'd8,
    F_ADDU = 6'd33,
    F_SUBU = 6'd35,
    F_AND  = 6'd36,
    F_OR   = 6'd37,
    F_XOR  = 6'd38,
    F_NOR  = 6'd39,
    F_SLT  = 6'd42,
    F_SLTU = 6'd43
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

  typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_e;

  typedef struct packed {
    logic    reg_write;
    logic    dest_rd;
    logic    dest_ra;
    logic    alu_src_imm;
    logic    imm_zero_ext;
    logic    shift_var;    // shift amount from rs[4:0]
    alu_op_e alu_op;
    logic    mem_read;
    logic    mem_write;
    wb_sel_e wb_sel;
    branch_e branch;
    logic    jump;
    logic    jump_reg;
  } ctrl_t;

endpackage

//--- verilog/mips_alu.sv
module mips_alu
  import mips_pkg::*;
(
  input  instr_t      instr,
  input  ctrl_t       ctrl,
  input  logic [31:0] rs_value,
  input  logic [31:0] rt_value,
  output logic [31:0] result,
  output logic        zero
);

  logic [31:0] imm_ext;
  logic [31:0] operand_b;
  logic [4:0]  shift_amount;

  assign imm_ext = ctrl.imm_zero_ext ? {16'd0, instr.i.imm}
                                     : {{16{instr.i.imm[15]}}, instr.i.imm};

  assign operand_b    = ctrl.alu_src_imm ? imm_ext : rt_value;
  assign shift_amount = ctrl.shift_var ? rs_value[4:0] : instr.r.shamt;

  always_comb
  begin
    case (ctrl.alu_op)
      ALU_ADD:  result = rs_value + operand_b;
      ALU_SUB:  result = rs_value - operand_b;
      ALU_AND:  result = rs_value & operand_b;
      ALU_OR:   result = rs_value | operand_b;
      ALU_XOR:  result = rs_value ^ operand_b;
      ALU_NOR:  result = ~(rs_value | operand_b);
      ALU_SLT:  result = {31'd0, $signed(rs_value) < $signed(operand_b)};
      ALU_SLTU: result = {31'd0, rs_value < operand_b};
      // Shifts always act on rt
      ALU_SLL:  result = rt_value << shift_amount;
      ALU_SRL:  result = rt_value >> shift_amount;
      ALU_SRA:  result = $unsigned($signed(rt_value) >>> shift_amount);
      ALU_LUI:  result = {instr.i.imm, 16'd0};
      default:  result = 32'd0;
    endcase
  end

  // Equality of the register operands for beq and bne
  assign zero = (rs_value == rt_value);

endmodule

//--- verilog/mips_control.sv
module mips_control
  import mips_pkg::*;
(
  input  instr_t instr,
  output ctrl_t  ctrl,
  output logic   illegal
);

  always_comb
  begin
    ctrl    = '0;
    illegal = 1'b0;
    case (instr.r.opcode)
      OP_SPECIAL:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.dest_rd   = 1'b1;
        case (instr.r.funct)
          F_ADDU: ctrl.alu_op = ALU_ADD;
          F_SUBU: ctrl.alu_op = ALU_SUB;
          F_AND:  ctrl.alu_op = ALU_AND;
          F_OR:   ctrl.alu_op = ALU_OR;
          F_XOR:  ctrl.alu_op = ALU_XOR;
          F_NOR:  ctrl.alu_op = ALU_NOR;
          F_SLT:  ctrl.alu_op = ALU_SLT;
          F_SLTU: ctrl.alu_op = ALU_SLTU;
          F_SLL:  ctrl.alu_op = ALU_SLL;
          F_SRL:  ctrl.alu_op = ALU_SRL;
          F_SRA:  ctrl.alu_op = ALU_SRA;
          F_SLLV, F_SRLV, F_SRAV:
          begin
            ctrl.shift_var = 1'b1;
            case (instr.r.funct)
              F_SLLV:  ctrl.alu_op = ALU_SLL;
              F_SRLV:  ctrl.alu_op = ALU_SRL;
              default: ctrl.alu_op = ALU_SRA;
            endcase
          end
          F_JR:
          begin
            ctrl.reg_write = 1'b0;
            ctrl.dest_rd   = 1'b0;
            ctrl.jump_reg  = 1'b1;
          end
          default:
          begin
            ctrl    = '0;
            illegal = 1'b1;
          end
        endcase
      end
      OP_J:     ctrl.jump = 1'b1;
      OP_JAL:
      begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dest_ra   = 1'b1;
        ctrl.wb_sel    = WB_LINK;
      end
      // Branch compare uses the ALU zero flag on rs and rt
      OP_BEQ:   ctrl.branch = BR_EQ;
      OP_BNE:   ctrl.branch = BR_NE;
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW:
      begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = instr.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI};
        case (instr.i.opcode)
          OP_SLTI: ctrl.alu_op = ALU_SLT;
          OP_ANDI: ctrl.alu_op = ALU_AND;
          OP_ORI:  ctrl.alu_op = ALU_OR;
          OP_XORI: ctrl.alu_op = ALU_XOR;
          OP_LUI:  ctrl.alu_op = ALU_LUI;
          default: ctrl.alu_op = ALU_ADD;
        endcase
        if (instr.i.opcode == OP_LW)
        begin
          ctrl.mem_read = 1'b1;
          ctrl.wb_sel   = WB_MEM;
        end
      end
      OP_SW:
      begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      default:  illegal = 1'b1;
    endcase
  end

endmodule

//--- verilog/mips_regfile.sv
module mips_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic        write_en,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] write_data,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data,
  output logic [31:0] register_v0
);

  logic [31:0] regs [32];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int r = 0; r < 32; r++)
        regs[r] <= 32'd0;
    end
    // $zero is never written
    else if (write_en && rd_addr != 5'd0)
    begin
      regs[rd_addr] <= write_data;
    end
  end

  assign rs_data     = regs[rs_addr];
  assign rt_data     = regs[rt_addr];
  assign register_v0 = regs[2];

  // Register 0 reads as zero on both ports
  a_zero_reg: assert property (@(posedge clk) disable iff (reset)
    (rs_addr != 5'd0 || rs_data == 32'd0) && (rt_addr != 5'd0 || rt_data == 32'd0));

endmodule

//--- verilog/mips_fetch.sv
module mips_fetch
  import mips_pkg::*;
#(
  parameter logic [31:0] RESET_VECTOR = 32'hBFC0_0000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        advance,
  input  instr_t      instr,
  input  ctrl_t       ctrl,
  input  logic        alu_zero,
  input  logic [31:0] rs_value,
  output logic [31:0] pc,
  output logic [31:0] link_addr
);

  logic [31:0] pc_plus4;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic [31:0] target;
  logic        taken;
  logic        redirect_valid;
  logic [31:0] redirect_target;

  assign pc_plus4  = pc + 32'd4;
  assign link_addr = pc + 32'd8;

  assign branch_target = pc_plus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j.index, 2'b00};

  always_comb
  begin
    if (ctrl.jump_reg)
      target = rs_value;
    else if (ctrl.jump)
      target = jump_target;
    else
      target = branch_target;
  end

  assign taken = ctrl.jump || ctrl.jump_reg ||
                 (ctrl.branch == BR_EQ && alu_zero) ||
                 (ctrl.branch == BR_NE && !alu_zero);

  // Redirect is held one instruction so the delay slot runs first
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc             <= RESET_VECTOR;
      redirect_valid <= 1'b0;
    end
    else if (advance)
    begin
      pc             <= redirect_valid ? redirect_target : pc_plus4;
      redirect_valid <= taken;
    end
  end

  always_ff @(posedge clk)
  begin
    if (advance)
      redirect_target <= target;
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- verilog/mips_cpu_harvard.sv
module mips_cpu_harvard
  import mips_pkg::*;
#(
  parameter logic [31:0] RESET_VECTOR = 32'hBFC0_0000
) (
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,
  input  logic        clk_enable,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  instr_t      instr;
  ctrl_t       ctrl;
  logic        illegal;
  logic        running;
  logic        advance;
  logic        alu_zero;
  logic [31:0] alu_result;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] link_addr;
  logic [4:0]  dest_reg;
  logic [31:0] write_data;

  assign instr = instr_t'(instr_readdata);

  // Address zero is the halt address and is never executed
  assign running = active && (instr_address != 32'd0);
  assign advance = clk_enable && running;

  always_ff @(posedge clk)
  begin
    if (reset)
      active <= 1'b1;
    else if (clk_enable && instr_address == 32'd0)
      active <= 1'b0;
  end

  mips_fetch #(.RESET_VECTOR(RESET_VECTOR)) i_fetch (
    .clk       (clk),
    .reset     (reset),
    .advance   (advance),
    .instr     (instr),
    .ctrl      (ctrl),
    .alu_zero  (alu_zero),
    .rs_value  (rs_data),
    .pc        (instr_address),
    .link_addr (link_addr)
  );

  mips_control i_control (
    .instr   (instr),
    .ctrl    (ctrl),
    .illegal (illegal)
  );

  // Destination is rt for I-type, rd for R-type, $31 for jal
  assign dest_reg = ctrl.dest_ra ? 5'd31 : (ctrl.dest_rd ? instr.r.rd : instr.r.rt);

  always_comb
  begin
    case (ctrl.wb_sel)
      WB_MEM:  write_data = data_readdata;
      WB_LINK: write_data = link_addr;
      default: write_data = alu_result;
    endcase
  end

  mips_regfile i_regfile (
    .clk         (clk),
    .reset       (reset),
    .write_en    (advance && ctrl.reg_write),
    .rs_addr     (instr.r.rs),
    .rt_addr     (instr.r.rt),
    .rd_addr     (dest_reg),
    .write_data  (write_data),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .register_v0 (register_v0)
  );

  mips_alu i_alu (
    .instr    (instr),
    .ctrl     (ctrl),
    .rs_value (rs_data),
    .rt_value (rt_data),
    .result   (alu_result),
    .zero     (alu_zero)
  );

  assign data_address   = alu_result;
  assign data_writedata = rt_data;
  assign data_read      = ctrl.mem_read && running;
  assign data_write     = ctrl.mem_write && running;

  a_mem_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(data_read && data_write));

  a_no_illegal: assert property (@(posedge clk) disable iff (reset)
    running |-> !illegal);

endmodule

//--- verification/mips_ref_model.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// Data memory contents before a run, a function of the word index
function automatic logic [31:0] fill_word(input int a);
  return {a[15:0] ^ 16'hC35A, ~a[15:0]};
endfunction

// Instruction-set model of the program in imem, with one delay slot
function automatic void mips_ref_model(output logic [31:0] v0, output int count);
  logic [31:0] regs [32];
  logic [31:0] pc;
  logic [31:0] npc;
  logic [31:0] seq;
  logic [31:0] ir;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] simm;
  logic [31:0] zimm;
  logic [31:0] addr;
  logic [31:0] res;
  logic [31:0] target;
  logic [4:0]  dest;
  logic        wr;
  logic        taken;
  for (int r = 0; r < 32; r++)
    regs[r] = 32'd0;
  for (int w = 0; w < 1024; w++)
    exp_mem[w] = fill_word(w);
  pc = RESET_VECTOR;
  npc = RESET_VECTOR + 32'd4;
  count = 0;
  while (pc != 32'd0 && count < MODEL_LIMIT)
  begin
    ir = imem.exists({2'b00, pc[31:2]}) ? imem[{2'b00, pc[31:2]}] : 32'd0;
    a = regs[ir[25:21]];
    b = regs[ir[20:16]];
    seq = pc + 32'd4;
    simm = {{16{ir[15]}}, ir[15:0]};
    zimm = {16'd0, ir[15:0]};
    addr = a + simm;
    res = 32'd0;
    dest = ir[20:16];
    wr = 1'b1;
    taken = 1'b0;
    target = 32'd0;
    case (ir[31:26])
      OP_SPECIAL:
      begin
        dest = ir[15:11];
        case (ir[5:0])
          F_ADDU: res = a + b;
          F_SUBU: res = a - b;
          F_AND:  res = a & b;
          F_OR:   res = a | b;
          F_XOR:  res = a ^ b;
          F_NOR:  res = ~(a | b);
          F_SLT:  res = {31'd0, $signed(a) < $signed(b)};
          F_SLTU: res = {31'd0, a < b};
          F_SLL:  res = b << ir[10:6];
          F_SRL:  res = b >> ir[10:6];
          F_SRA:  res = $signed(b) >>> ir[10:6];
          F_SLLV: res = b << a[4:0];
          F_SRLV: res = b >> a[4:0];
          F_SRAV: res = $signed(b) >>> a[4:0];
          F_JR:
          begin
            wr = 1'b0;
            taken = 1'b1;
            target = a;
          end
          default: wr = 1'b0;
        endcase
      end
      OP_J, OP_JAL:
      begin
        wr = (ir[31:26] == OP_JAL);
        dest = 5'd31;
        res = pc + 32'd8;
        taken = 1'b1;
        target = {seq[31:28], ir[25:0], 2'b00};
      end
      OP_BEQ, OP_BNE:
      begin
        wr = 1'b0;
        taken = (ir[31:26] == OP_BEQ) ? (a == b) : (a != b);
        target = seq + (simm << 2);
      end
      OP_ADDIU: res = a + simm;
      OP_SLTI:  res = {31'd0, $signed(a) < $signed(simm)};
      OP_ANDI:  res = a & zimm;
      OP_ORI:   res = a | zimm;
      OP_XORI:  res = a ^ zimm;
      OP_LUI:   res = {ir[15:0], 16'd0};
      OP_LW:    res = exp_mem[addr[11:2]];
      OP_SW:
      begin
        wr = 1'b0;
        exp_mem[addr[11:2]] = b;
      end
      default:  wr = 1'b0;
    endcase
    if (wr && dest != 5'd0)
      regs[dest] = res;
    pc = npc;
    npc = taken ? target : npc + 32'd4;
    count++;
  end
  v0 = regs[2];
endfunction

`endif

//--- verification/mips_tb.sv
module mips_tb
  import mips_pkg::*;
;

  localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;
  localparam int HALT_TIMEOUT = 5000;
  localparam int MODEL_LIMIT = 10000;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        clk_enable = 1'b0;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;

  logic [31:0] imem [int unsigned];
  logic [31:0] dmem [1024];
  logic [31:0] exp_mem [1024];
  logic [31:0] prog [$];
  int          gap_pct = 0;
  int          enabled_cycles;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  `include "mips_ref_model.svh"

  mips_cpu_harvard #(.RESET_VECTOR(RESET_VECTOR)) i_mips_cpu_harvard (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  always #10 clk = ~clk;

  always_comb
  begin
    if (imem.exists({2'b00, instr_address[31:2]}))
      instr_readdata = imem[{2'b00, instr_address[31:2]}];
    else
      instr_readdata = 32'd0;
  end

  assign data_readdata = dmem[data_address[11:2]];

  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int a = 0; a < 1024; a++)
        dmem[a] <= fill_word(a);
    end
    else if (data_write && clk_enable)
      dmem[data_address[11:2]] <= data_writedata;
  end

  // Random enable gaps, gap_pct percent of cycles held off
  always @(posedge clk)
  begin
    if (gap_pct == 0)
      clk_enable <= 1'b1;
    else
      clk_enable <= ($urandom_range(99) >= gap_pct);
  end

  // Executed instructions: enabled edges while running
  always @(posedge clk)
  begin
    if (reset)
      enabled_cycles <= 0;
    else if (clk_enable && active && instr_address != 32'd0)
      enabled_cycles <= enabled_cycles + 1;
  end

  function automatic logic [31:0] r_type(input funct_e f, input int rd, input int rs,
                                         input int rt, input int sh);
    return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sh[4:0], f};
  endfunction

  function automatic logic [31:0] i_type(input opcode_e op, input int rt, input int rs,
                                         input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] j_type(input opcode_e op, input logic [31:0] target);
    return {op, target[27:2]};
  endfunction

  task automatic load_const(input int r, input logic [31:0] value);
    prog.push_back(i_type(OP_LUI, r, 0, value[31:16]));
    prog.push_back(i_type(OP_ORI, r, r, value[15:0]));
  endtask

  // jr $0 and its delay slot
  task automatic end_program();
    prog.push_back(r_type(F_JR, 0, 0, 0, 0));
    prog.push_back(32'd0);
  endtask

  task automatic check_value(input string signal, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR at %0t: %s expected %h, actual %h", $time, signal, expected, actual);
      errors++;
    end
  endtask

  // Data read strobe only for a load being executed
  always @(negedge clk)
  begin
    if (!reset)
      check_value("data_read",
                  {31'd0, active && instr_address != 32'd0 &&
                          instr_readdata[31:26] == OP_LW},
                  {31'd0, data_read});
  end

  task automatic reset_dut();
    @(posedge clk);
    reset <= 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic alu_program();
    logic [31:0] a;
    logic [31:0] b;
    int sh;
    prog.delete();
    a = $urandom();
    b = $urandom();
    sh = $urandom_range(31);
    load_const(8, a);
    load_const(9, b);
    prog.push_back(r_type(F_ADDU, 10, 8, 9, 0));
    prog.push_back(r_type(F_SUBU, 11, 8, 9, 0));
    prog.push_back(r_type(F_AND, 12, 8, 9, 0));
    prog.push_back(r_type(F_OR, 13, 8, 9, 0));
    prog.push_back(r_type(F_XOR, 14, 8, 9, 0));
    prog.push_back(r_type(F_NOR, 15, 8, 9, 0));
    prog.push_back(r_type(F_SLT, 16, 8, 9, 0));
    prog.push_back(r_type(F_SLTU, 17, 8, 9, 0));
    prog.push_back(r_type(F_SLL, 18, 0, 9, sh));
    prog.push_back(r_type(F_SRL, 19, 0, 8, sh));
    prog.push_back(r_type(F_SRA, 20, 0, 8, sh));
    prog.push_back(r_type(F_SRAV, 21, 9, 8, 0));
    prog.push_back(r_type(F_SLLV, 22, 8, 9, 0));
    prog.push_back(i_type(OP_ADDIU, 23, 8, $urandom_range(16'hFFFF)));
    prog.push_back(i_type(OP_SLTI, 24, 9, $urandom_range(16'hFFFF)));
    prog.push_back(i_type(OP_ANDI, 25, 8, $urandom_range(16'hFFFF)));
    prog.push_back(i_type(OP_ORI, 26, 9, $urandom_range(16'hFFFF)));
    prog.push_back(i_type(OP_XORI, 27, 8, $urandom_range(16'hFFFF)));
    prog.push_back(i_type(OP_LUI, 28, 0, $urandom_range(16'hFFFF)));
    // Each result to memory, then rotated into v0
    for (int k = 10; k <= 28; k++)
    begin
      prog.push_back(i_type(OP_SW, k, 0, 4 * k));
      prog.push_back(r_type(F_XOR, 2, 2, k, 0));
      prog.push_back(r_type(F_SLL, 3, 0, 2, 5));
      prog.push_back(r_type(F_SRL, 2, 0, 2, 27));
      prog.push_back(r_type(F_OR, 2, 2, 3, 0));
    end
    end_program();
  endtask

  task automatic memory_program();
    prog.delete();
    load_const(8, 32'h200 + 4 * $urandom_range(63));
    prog.push_back(i_type(OP_ADDIU, 9, 8, 24));
    for (int k = 0; k < 6; k++)
    begin
      load_const(5, $urandom());
      prog.push_back(i_type(OP_SW, 5, 8, 4 * k));
    end
    // Read back through the second base with negative offsets
    for (int k = 0; k < 6; k++)
    begin
      prog.push_back(i_type(OP_LW, 6, 9, 4 * k - 24));
      prog.push_back(r_type(F_ADDU, 2, 2, 6, 0));
      prog.push_back(i_type(OP_SW, 6, 8, 4 * k + 64));
    end
    prog.push_back(i_type(OP_LW, 10, 8, 128));
    prog.push_back(r_type(F_XOR, 2, 2, 10, 0));
    prog.push_back(i_type(OP_SW, 2, 9, -4));
    end_program();
  endtask

  // Branch, delay slot, fall-through, target; taken skips the fall-through
  task automatic branch_case(input opcode_e op, input int rs, input int rt, input int tag);
    if (op == OP_J)
      prog.push_back(j_type(OP_J, RESET_VECTOR + 4 * (prog.size() + 3)));
    else
      prog.push_back(i_type(op, rt, rs, 2));
    prog.push_back(i_type(OP_ADDIU, 2, 2, tag));
    prog.push_back(i_type(OP_ADDIU, 2, 2, tag << 4));
    prog.push_back(i_type(OP_ADDIU, 2, 2, tag << 8));
  endtask

  task automatic branch_program();
    logic [31:0] v;
    prog.delete();
    v = $urandom();
    load_const(8, v);
    load_const(9, v);
    load_const(10, v ^ 32'h10);
    branch_case(OP_BEQ, 8, 9, 1);
    branch_case(OP_BEQ, 8, 10, 2);
    branch_case(OP_BNE, 8, 10, 3);
    branch_case(OP_BNE, 8, 9, 4);
    branch_case(OP_J, 0, 0, 5);
    // Backward loop of five passes
    prog.push_back(i_type(OP_ADDIU, 11, 0, 5));
    prog.push_back(i_type(OP_ADDIU, 11, 11, -1));
    prog.push_back(i_type(OP_BNE, 0, 11, -2));
    prog.push_back(i_type(OP_ADDIU, 2, 2, 3));
    end_program();
  endtask

  task automatic call_program();
    int p;
    prog.delete();
    prog.push_back(i_type(OP_ADDIU, 4, 0, $urandom_range(16'h7FFF)));
    p = prog.size();
    prog.push_back(j_type(OP_JAL, RESET_VECTOR + 4 * (p + 6)));
    prog.push_back(i_type(OP_ADDIU, 2, 4, 1));
    prog.push_back(r_type(F_ADDU, 2, 2, 31, 0));
    prog.push_back(i_type(OP_SW, 31, 0, 64));
    end_program();
    // Subroutine
    prog.push_back(r_type(F_SLL, 2, 0, 2, 1));
    prog.push_back(r_type(F_JR, 0, 31, 0, 0));
    prog.push_back(i_type(OP_ADDIU, 2, 2, 7));
  endtask

  task automatic zero_reg_program();
    prog.delete();
    load_const(3, $urandom());
    prog.push_back(i_type(OP_ADDIU, 0, 3, 16'h55));
    prog.push_back(r_type(F_ADDU, 0, 3, 3, 0));
    prog.push_back(i_type(OP_LUI, 0, 0, 16'h1234));
    prog.push_back(i_type(OP_LW, 0, 0, 256));
    prog.push_back(r_type(F_ADDU, 2, 0, 3, 0));
    prog.push_back(i_type(OP_SW, 0, 0, 128));
    end_program();
  endtask

  task automatic run_program(input string name, input int gap);
    logic [31:0] exp_v0;
    logic [31:0] held_v0;
    int exp_count;
    int cycles;
    int errors_before;
    errors_before = errors;
    imem.delete();
    foreach (prog[k])
      imem[(RESET_VECTOR >> 2) + k] = prog[k];
    // Store at the halt address and the v0 update after it must never run
    imem[0] = i_type(OP_SW, 2, 0, 0);
    imem[1] = i_type(OP_ADDIU, 2, 2, 1);
    mips_ref_model(exp_v0, exp_count);
    gap_pct = gap;
    reset_dut();
    cycles = 0;
    while (active !== 1'b0 && cycles < HALT_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (active !== 1'b0)
    begin
      $display("Test %s: program did not halt within %0d cycles", name, HALT_TIMEOUT);
      errors++;
    end
    else
    begin
      held_v0 = register_v0;
      repeat (20)
      begin
        @(negedge clk);
        check_value("data_write", 32'd0, {31'd0, data_write});
        check_value("register_v0 after halt", held_v0, register_v0);
      end
      check_value("register_v0", exp_v0, register_v0);
      check_value("enabled_cycles", exp_count, enabled_cycles);
      for (int a = 0; a < 1024; a++)
        check_value($sformatf("dmem[%0d]", a), exp_mem[a], dmem[a]);
    end
    tests_run++;
    if (errors != errors_before)
      tests_failed++;
    $display("Test %s: %s", name, (errors == errors_before) ? "passed" : "failed");
  endtask

  initial
  begin
    logic [31:0] alu_v0;
    void'($urandom(24));
    alu_program();
    run_program("alu", 0);
    alu_v0 = register_v0;
    run_program("clk_enable", 30);
    check_value("register_v0 with gaps", alu_v0, register_v0);
    memory_program();
    run_program("load_store", 0);
    branch_program();
    run_program("delay_slot", 0);
    call_program();
    run_program("jal_jr", 0);
    zero_reg_program();
    run_program("halt_zero_reg", 0);
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- tb.f
+incdir+verification
verilog/mips_pkg.sv
verilog/mips_alu.sv
verilog/mips_control.sv
verilog/mips_regfile.sv
verilog/mips_fetch.sv
verilog/mips_cpu_harvard.sv
verification/mips_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the MIPS core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f tb.f \
  --top-module mips_tb \
  -Mdir obj_dir

./obj_dir/Vmips_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log
then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
